// File: common/busCfg.svh
// Bus configuration: address map, data memory depth and timer register indices
`ifndef BUS_CFG_SVH
`define BUS_CFG_SVH

// Data memory range
`define DATA_STARTADDR   32'h0000_0000
`define DATA_ENDADDR     32'h0000_2FFF

// Whole device window behind the south bridge
`define DEV_STARTADDR    32'h0000_7F00
`define DEV_ENDADDR      32'h0000_7F1F

// Timer ranges inside the device window
`define TIMER0_STARTADDR 32'h0000_7F00
`define TIMER0_ENDADDR   32'h0000_7F0B
`define TIMER1_STARTADDR 32'h0000_7F10
`define TIMER1_ENDADDR   32'h0000_7F1B

// Data memory depth in words
`define DM_WORDS         3072

// Timer register index, address bits 3:2
`define REG_CTRL         2'd0
`define REG_PRESET       2'd1
`define REG_COUNT        2'd2

`endif

// File: common/busPkg.sv
// Bus package: word, address and interrupt types plus the timer state encoding
package busPkg;

    // Byte address from the CPU data port
    typedef logic [31:0] addrT;

    // Data word on every bus
    typedef logic [31:0] wordT;

    // One enable per byte lane
    typedef logic [3:0] byteEnT;

    // Hardware interrupt lines 7 down to 2
    typedef logic [5:0] hwIntT;

    // Countdown timer FSM
    typedef enum logic [1:0] {
        idle  = 2'd0,
        load  = 2'd1,
        count = 2'd2,
        irq   = 2'd3
    } timerStateT;

endpackage

// File: common/devBusIf.sv
// Device bus: word address, write data, whole-word write strobe and read data
interface devBusIf;
    import busPkg::*;

    addrT addr;
    wordT wdata;
    logic we;
    wordT rdata;

    // Bridge side drives the request
    modport host (
        output addr,
        output wdata,
        output we,
        input  rdata
    );

    // Device answers with read data
    modport device (
        input  addr,
        input  wdata,
        input  we,
        output rdata
    );

endinterface

// File: bridge/northBridge.sv
// North bridge: splits the CPU data port between data memory and the device window
`include "busCfg.svh"

module northBridge (
    input  busPkg::addrT   cpuAddr,
    input  busPkg::wordT   cpuWdata,
    input  busPkg::byteEnT cpuByteEn,
    output busPkg::wordT   cpuRdata,
    output busPkg::addrT   dmAddr,
    output busPkg::wordT   dmWdata,
    output busPkg::byteEnT dmByteEn,
    input  busPkg::wordT   dmRdata,
    devBusIf.host          sbr
);

    logic inData;
    logic inDev;

    assign inData = (cpuAddr >= `DATA_STARTADDR) && (cpuAddr <= `DATA_ENDADDR);
    assign inDev  = (cpuAddr >= `DEV_STARTADDR) && (cpuAddr <= `DEV_ENDADDR);

    // Data memory takes byte lanes only inside its range
    assign dmAddr   = cpuAddr;
    assign dmWdata  = cpuWdata;
    assign dmByteEn = inData ? cpuByteEn : 4'b0000;

    // Devices only accept full-word stores
    assign sbr.addr  = cpuAddr;
    assign sbr.wdata = cpuWdata;
    assign sbr.we    = inDev && (&cpuByteEn);

    // Unmapped reads return zero
    assign cpuRdata = inData ? dmRdata :
                      inDev  ? sbr.rdata :
                      '0;

    // Memory and device window never share a store
    always_comb begin
        assert (!((|dmByteEn) && sbr.we))
            else $error("northBridge: memory and device written together");
    end

endmodule

// File: bridge/southBridge.sv
// South bridge: routes the device window to the two timers and packs the interrupt vector
`include "busCfg.svh"

module southBridge (
    devBusIf.device      cpu,
    devBusIf.host        t0,
    devBusIf.host        t1,
    input  logic         t0Irq,
    input  logic         t1Irq,
    input  logic         extInt,
    output busPkg::hwIntT hwInt
);

    logic selT0;
    logic selT1;

    // Timer ranges, the gaps between them stay unmapped
    assign selT0 = (cpu.addr >= `TIMER0_STARTADDR) && (cpu.addr <= `TIMER0_ENDADDR);
    assign selT1 = (cpu.addr >= `TIMER1_STARTADDR) && (cpu.addr <= `TIMER1_ENDADDR);

    // Timer 0
    assign t0.addr  = cpu.addr;
    assign t0.wdata = cpu.wdata;
    assign t0.we    = cpu.we && selT0;

    // Timer 1
    assign t1.addr  = cpu.addr;
    assign t1.wdata = cpu.wdata;
    assign t1.we    = cpu.we && selT1;

    assign cpu.rdata = selT0 ? t0.rdata :
                       selT1 ? t1.rdata :
                       '0;

    // Lines 7:2, top three unused
    assign hwInt = {3'b000, extInt, t1Irq, t0Irq};

    // At most one timer sees a store
    always_comb begin
        assert (!(t0.we && t1.we))
            else $error("southBridge: both timers written together");
    end

endmodule

// File: source/dataMem.sv
// Data memory: word-wide RAM with per-byte write enables and asynchronous read
`include "busCfg.svh"

module dataMem (
    input  logic           clk,
    input  busPkg::addrT   addr,
    input  busPkg::wordT   wdata,
    input  busPkg::byteEnT byteEn,
    output busPkg::wordT   rdata
);
    import busPkg::*;

    wordT mem [`DM_WORDS];
    logic [11:0] wordIdx;

    // Byte address to word index
    assign wordIdx = addr[13:2];

    always_ff @(posedge clk) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (byteEn[lane]) begin
                mem[wordIdx][8*lane +: 8] <= wdata[8*lane +: 8];
            end
        end
    end

    // Combinational read, same cycle as the address
    assign rdata = mem[wordIdx];

    // Bridge decoding keeps stores inside the array
    assert property (@(posedge clk) (|byteEn) |-> (wordIdx < `DM_WORDS))
        else $error("dataMem: store outside the memory array");

endmodule

// File: source/timer.sv
// Timer: programmable countdown with one-shot and auto-reload modes and a maskable interrupt
`include "busCfg.svh"

module timer (
    input  logic    clk,
    input  logic    rst,
    devBusIf.device bus,
    output logic    irq
);
    import busPkg::*;

    // CTRL holds mask, mode and enable in bits 3:0
    logic [3:0] ctrlReg;
    logic [3:0] ctrlNext;
    wordT       presetReg;
    wordT       countReg;
    wordT       countNext;
    timerStateT state;
    timerStateT stateNext;
    logic [1:0] regIdx;
    logic       ctrlWr;
    logic       presetWr;
    logic       stopReq;
    logic       autoReload;

    assign regIdx     = bus.addr[3:2];
    assign ctrlWr     = bus.we && (regIdx == `REG_CTRL);
    assign presetWr   = bus.we && (regIdx == `REG_PRESET);
    assign stopReq    = ctrlWr && !bus.wdata[0];
    assign autoReload = (ctrlReg[2:1] == 2'd1);

    always_comb begin
        ctrlNext  = ctrlWr ? bus.wdata[3:0] : ctrlReg;
        stateNext = state;
        countNext = countReg;
        if (stopReq) begin
            // Count is held where it stopped
            stateNext = idle;
        end else begin
            case (state)
                idle: begin
                    if (ctrlWr) begin
                        stateNext = load;
                    end
                end
                load: begin
                    countNext = presetReg;
                    stateNext = (presetReg == '0) ? busPkg::irq : count;
                end
                count: begin
                    countNext = countReg - 32'd1;
                    if (countReg == 32'd1) begin
                        stateNext = busPkg::irq;
                    end
                end
                busPkg::irq: begin
                    // One-shot waits here for a fresh CTRL write
                    if (autoReload || ctrlWr) begin
                        stateNext = load;
                    end
                end
            endcase
            // One-shot drops enable on the way into irq
            if ((stateNext == busPkg::irq) && (ctrlNext[2:1] != 2'd1)) begin
                ctrlNext[0] = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= idle;
            ctrlReg   <= '0;
            presetReg <= '0;
            countReg  <= '0;
        end else begin
            state    <= stateNext;
            ctrlReg  <= ctrlNext;
            countReg <= countNext;
            if (presetWr) begin
                presetReg <= bus.wdata;
            end
        end
    end

    // Register readback, COUNT is read-only
    always_comb begin
        case (regIdx)
            `REG_CTRL:   bus.rdata = {28'd0, ctrlReg};
            `REG_PRESET: bus.rdata = presetReg;
            `REG_COUNT:  bus.rdata = countReg;
            default:     bus.rdata = '0;
        endcase
    end

    assign irq = (state == busPkg::irq) && ctrlReg[3];

    // Once loaded the count only steps down, or holds when stopped
    assert property (@(posedge clk) disable iff (rst)
        (state == count) |=> ((countReg == $past(countReg) - 32'd1) || (state == idle)))
        else $error("timer: count did not step down");

    // Auto-reload interrupt is a single-cycle pulse
    assert property (@(posedge clk) disable iff (rst) (irq && autoReload) |=> !irq)
        else $error("timer: auto-reload interrupt longer than one cycle");

endmodule

// File: source/sysBus.sv
// System bus: CPU data port decoding into data memory and two timers with interrupt vector
module sysBus (
    input  logic           clk,
    input  logic           rst,
    input  busPkg::addrT   addr,
    input  busPkg::wordT   wdata,
    input  busPkg::byteEnT byteEn,
    output busPkg::wordT   rdata,
    input  logic           extInt,
    output busPkg::hwIntT  hwInt
);
    import busPkg::*;

    // Data memory side of the north bridge
    addrT   dmAddr;
    wordT   dmWdata;
    byteEnT dmByteEn;
    wordT   dmRdata;

    logic t0Irq;
    logic t1Irq;

    // North to south, then south to each timer
    devBusIf sbrBus ();
    devBusIf t0Bus ();
    devBusIf t1Bus ();

    northBridge northBridge_inst (
        .cpuAddr   (addr),
        .cpuWdata  (wdata),
        .cpuByteEn (byteEn),
        .cpuRdata  (rdata),
        .dmAddr    (dmAddr),
        .dmWdata   (dmWdata),
        .dmByteEn  (dmByteEn),
        .dmRdata   (dmRdata),
        .sbr       (sbrBus.host)
    );

    dataMem dataMem_inst (
        .clk    (clk),
        .addr   (dmAddr),
        .wdata  (dmWdata),
        .byteEn (dmByteEn),
        .rdata  (dmRdata)
    );

    southBridge southBridge_inst (
        .cpu    (sbrBus.device),
        .t0     (t0Bus.host),
        .t1     (t1Bus.host),
        .t0Irq  (t0Irq),
        .t1Irq  (t1Irq),
        .extInt (extInt),
        .hwInt  (hwInt)
    );

    timer timer0_inst (
        .clk (clk),
        .rst (rst),
        .bus (t0Bus.device),
        .irq (t0Irq)
    );

    timer timer1_inst (
        .clk (clk),
        .rst (rst),
        .bus (t1Bus.device),
        .irq (t1Irq)
    );

endmodule

// File: verif/sysBusTb.sv
// System bus testbench driving random CPU accesses against a model of memory and timers
`include "busCfg.svh"

module sysBusTb;
    import busPkg::*;

    localparam int MEM_OPS = 300;
    localparam int DEC_OPS = 120;
    localparam int REG_OPS = 20;
    // Twice the planned cycles of all phases
    localparam int CYCLE_LIMIT = 2 * (8 + 2 * MEM_OPS + 2 * DEC_OPS + 12 * REG_OPS
                                      + 8 * 25 + 2 * 45);

    logic   clk = 1'b0;
    logic   rst;
    addrT   addr;
    wordT   wdata;
    byteEnT byteEn;
    wordT   rdata;
    logic   extInt;
    hwIntT  hwInt;

    logic [31:0] rngState = 32'd55;
    int          cycleCount = 0;
    hwIntT       seenHwInt;

    // Reference state
    wordT       memModel [int];
    int         memKeys [$];
    logic [3:0] ctrlM [2];
    wordT       presetM [2];
    wordT       countM [2];
    timerStateT stateM [2];

    sysBus sysBus_inst (
        .clk    (clk),
        .rst    (rst),
        .addr   (addr),
        .wdata  (wdata),
        .byteEn (byteEn),
        .rdata  (rdata),
        .extInt (extInt),
        .hwInt  (hwInt)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("Run did not finish within %0d cycles", CYCLE_LIMIT);
            stopOnFailure();
        end
    end

    task automatic stopOnFailure();
        $display("=== FAIL ===");
        $fatal(1, "Stopping at the first failure");
    endtask

    task automatic checkEq(input string testName, input logic [31:0] expected,
                           input logic [31:0] actual);
        assert (actual === expected)
        else begin
            $display("ERROR %s: expected %h, actual %h", testName, expected, actual);
            stopOnFailure();
        end
    endtask

    function automatic logic [31:0] nextRand();
        logic [31:0] x;
        x = rngState;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rngState = x;
        return x;
    endfunction

    function automatic logic inRange(input addrT a, input addrT lo, input addrT hi);
        return (a >= lo) && (a <= hi);
    endfunction

    function automatic int memKey(input addrT a);
        return {20'd0, a[13:2]};
    endfunction

    function automatic int timerOf(input addrT a);
        if (inRange(a, `TIMER0_STARTADDR, `TIMER0_ENDADDR))
            return 0;
        if (inRange(a, `TIMER1_STARTADDR, `TIMER1_ENDADDR))
            return 1;
        return -1;
    endfunction

    function automatic addrT regAddr(input int t, input int k);
        return ((t == 1) ? `TIMER1_STARTADDR : `TIMER0_STARTADDR) + 32'(4 * k);
    endfunction

    function automatic wordT modelRead(input addrT a);
        int t;
        t = timerOf(a);
        if (inRange(a, `DATA_STARTADDR, `DATA_ENDADDR))
            return memModel[memKey(a)];
        if (t < 0)
            return '0;
        case (a[3:2])
            `REG_CTRL:   return {28'd0, ctrlM[t]};
            `REG_PRESET: return presetM[t];
            default:     return countM[t];
        endcase
    endfunction

    function automatic hwIntT modelHwInt();
        logic irq0;
        logic irq1;
        irq0 = (stateM[0] == irq) && ctrlM[0][3];
        irq1 = (stateM[1] == irq) && ctrlM[1][3];
        return {3'b000, extInt, irq1, irq0};
    endfunction

    // Advance the model by one rising edge
    task automatic stepModel(input addrT a, input wordT d, input byteEnT be);
        int         k;
        wordT       w;
        logic       wrCtrl;
        logic       wrPreset;
        logic [3:0] nCtrl;
        wordT       nCount;
        timerStateT nState;
        k = memKey(a);
        if (inRange(a, `DATA_STARTADDR, `DATA_ENDADDR) && (be == 4'hF || memModel.exists(k))) begin
            w = memModel.exists(k) ? memModel[k] : d;
            for (int lane = 0; lane < 4; lane++) begin
                if (be[lane])
                    w[8*lane +: 8] = d[8*lane +: 8];
            end
            memModel[k] = w;
        end
        for (int t = 0; t < 2; t++) begin
            // Devices see whole-word stores only
            wrCtrl   = (timerOf(a) == t) && (be == 4'hF) && (a[3:2] == `REG_CTRL);
            wrPreset = (timerOf(a) == t) && (be == 4'hF) && (a[3:2] == `REG_PRESET);
            nCtrl    = wrCtrl ? d[3:0] : ctrlM[t];
            nCount   = countM[t];
            nState   = stateM[t];
            if (wrCtrl && !d[0]) begin
                nState = idle;
            end else begin
                case (stateM[t])
                    idle: begin
                        if (wrCtrl)
                            nState = load;
                    end
                    load: begin
                        nCount = presetM[t];
                        nState = (presetM[t] == '0) ? irq : count;
                    end
                    count: begin
                        nCount = countM[t] - 32'd1;
                        if (countM[t] == 32'd1)
                            nState = irq;
                    end
                    irq: begin
                        if (ctrlM[t][2:1] == 2'd1 || wrCtrl)
                            nState = load;
                    end
                endcase
                // One-shot drops enable when it fires
                if (nState == irq && nCtrl[2:1] != 2'd1)
                    nCtrl[0] = 1'b0;
            end
            ctrlM[t]  = nCtrl;
            countM[t] = nCount;
            stateM[t] = nState;
            if (wrPreset)
                presetM[t] = d;
        end
    endtask

    // One bus cycle driven on the falling edge and checked before the rising edge
    task automatic busCycle(input string testName, input addrT a, input wordT d,
                            input byteEnT be);
        logic [31:0] r;
        r = nextRand();
        @(negedge clk);
        addr   = a;
        wdata  = d;
        byteEn = be;
        extInt = r[0];
        #1;
        if (!inRange(a, `DATA_STARTADDR, `DATA_ENDADDR) || memModel.exists(memKey(a)))
            checkEq(testName, modelRead(a), rdata);
        checkEq({testName, " hwInt"}, {26'd0, modelHwInt()}, {26'd0, hwInt});
        seenHwInt = hwInt;
        stepModel(a, d, be);
    endtask

    task automatic writeReg(input string testName, input int t, input int k, input wordT d);
        busCycle(testName, regAddr(t, k), d, 4'hF);
    endtask

    task automatic readReg(input string testName, input int t, input int k);
        busCycle(testName, regAddr(t, k), nextRand(), 4'h0);
    endtask

    task automatic readTimers(input string testName);
        for (int t = 0; t < 2; t++) begin
            for (int k = 0; k < 3; k++)
                readReg(testName, t, k);
        end
    endtask

    initial begin
        logic [31:0] r;
        addrT        a;
        byteEnT      be;
        int          key;
        int          period;
        int          lastPulse;
        rst    = 1'b1;
        addr   = '0;
        wdata  = '0;
        byteEn = '0;
        extInt = 1'b0;
        for (int t = 0; t < 2; t++) begin
            ctrlM[t]   = '0;
            presetM[t] = '0;
            countM[t]  = '0;
            stateM[t]  = idle;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Memory accesses where new words get a full store first
        for (int n = 0; n < MEM_OPS; n++) begin
            r = nextRand();
            if (r[0] || memKeys.size() == 0) begin
                key = int'(r[31:1] % 32'd3072);
                be  = memModel.exists(key) ? r[16:13] : 4'hF;
                if (!memModel.exists(key))
                    memKeys.push_back(key);
                busCycle("memory", addrT'(key * 4) + {30'd0, r[18:17]}, nextRand(), be);
            end else begin
                key = memKeys[r[31:1] % memKeys.size()];
                busCycle("memory", addrT'(key * 4), nextRand(), 4'h0);
            end
        end

        // Unmapped accesses and partial stores to timers
        for (int n = 0; n < DEC_OPS; n++) begin
            r = nextRand();
            case (r[1:0])
                2'd0:    a = {1'b1, r[31:1]};
                2'd1:    a = 32'h0000_3000 + (r[31:2] % 32'h4F00);
                2'd2:    a = 32'h0000_7F0C + {30'd0, r[3:2]};
                default: a = 32'h0000_7F1C + (r[31:2] % 32'hE4);
            endcase
            busCycle("decode", a, nextRand(), r[11:8]);
            r  = nextRand();
            be = (r[6:3] == 4'hF) ? 4'h7 : r[6:3];
            busCycle("decode", regAddr(int'(r[0]), int'(r[2:1] % 2'd3)), nextRand(), be);
        end
        foreach (memKeys[i])
            busCycle("decode", addrT'(memKeys[i] * 4), nextRand(), 4'h0);
        readTimers("decode");

        // Register access with enable held low
        for (int n = 0; n < REG_OPS; n++) begin
            for (int t = 0; t < 2; t++) begin
                r = nextRand();
                writeReg("registers", t, 1, nextRand());
                writeReg("registers", t, 0, {28'd0, r[3:1], 1'b0});
                writeReg("registers", t, 2, nextRand());
            end
            readTimers("registers");
        end

        // One-shot countdown with the mask clear on the last round
        for (int n = 0; n < 4; n++) begin
            for (int t = 0; t < 2; t++) begin
                r = nextRand();
                writeReg("one-shot", t, 1, {28'd0, r[3:0]});
                writeReg("one-shot", t, 0, {28'd0, (n != 3), 2'b00, 1'b1});
                while (stateM[t] != irq)
                    readReg("one-shot", t, 2);
                repeat (4) readReg("one-shot", t, 2);
                writeReg("one-shot", t, 0, 32'd0);
                readReg("one-shot", t, 0);
            end
        end

        // Auto-reload pulses once per preset plus 2 cycles
        for (int t = 0; t < 2; t++) begin
            r = nextRand();
            period    = int'(r[2:0]) + 3;
            lastPulse = -1;
            writeReg("auto-reload", t, 1, {29'd0, r[2:0]} + 32'd1);
            writeReg("auto-reload", t, 0, 32'h0000_000B);
            for (int c = 0; c < 4 * period; c++) begin
                readReg("auto-reload", t, 2);
                if (seenHwInt[t]) begin
                    if (lastPulse >= 0)
                        checkEq("auto-reload period", 32'(period), 32'(c - lastPulse));
                    lastPulse = c;
                end
            end
            assert (lastPulse >= 0)
            else begin
                $display("Auto-reload timer %0d never raised its interrupt", t);
                stopOnFailure();
            end
            writeReg("auto-reload", t, 0, 32'd0);
        end
        readTimers("final");

        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: sysBus.f
+incdir+common
common/busPkg.sv
common/devBusIf.sv
bridge/northBridge.sv
bridge/southBridge.sv
source/dataMem.sv
source/timer.sv
source/sysBus.sv
verif/sysBusTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the sysBus testbench with Verilator, run it and judge the log
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sysBus.f --top-module sysBusTb -o sysBusSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sysBusSim > sim.log 2>&1
simStatus=$?
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
    exit 1
fi
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi
exit 0
